/* include/gpu_bus_consts.svh */
`ifndef GPU_BUS_CONSTS_SVH
`define GPU_BUS_CONSTS_SVH

// ******************************
// z80 side of the bridge
// ******************************

`define Z80_MEM_RANGE    3'b011	// addr[21:19] of the 512KB window at 0x180000-0x1FFFFF
`define Z80_WR_DELAY     2	// cycles from 245 enable to write data latch
`define Z80_SYNC_STAGES  2	// flops per strobe in the pin synchronizer

// ******************************
// gpu ram side
// ******************************

`define GPU_ADDR_BITS    19	// byte address of the 512KB gpu ram

`endif

/* design/gpu_bus_pkg.sv */
`include "gpu_bus_consts.svh"

package gpu_bus_pkg;

	// ******************************
	// z80 control strobes, all active low but the clock
	// ******************************
	typedef struct packed {
		logic mreq_n;	// memory request
		logic m1_n;	// opcode fetch cycle
		logic wr_n;	// write strobe
		logic rd_n;	// read strobe
		logic clk;	// z80 cpu clock
	} z80_ctl_t;

	// request into a ram mux port
	typedef struct packed {
		logic [`GPU_ADDR_BITS-1:0] addr;	// byte address
		logic [7:0] wdata;	// write byte
		logic wr_ena;	// one cycle write strobe
		logic rd_req;	// one cycle read request
	} gpu_req_t;

	// answer from a ram mux port
	typedef struct packed {
		logic [7:0] rdata;	// valid while rd_rdy is high
		logic rd_rdy;	// one-shot, one per rd_req
	} gpu_rsp_t;

	// 245 translator control and read data toward the z80 pins
	typedef struct packed {
		logic data_dir;	// high = toward fpga
		logic xlat_oe;	// high = 245 enabled
		logic [7:0] rdata;	// byte driven onto the z80 data bus
		logic rdata_ena;	// high = fpga drives the data pins
	} z80_drv_t;

endpackage

/* design/z80_bus_sync.sv */
`timescale 1ns/1ps
`include "gpu_bus_consts.svh"

module z80_bus_sync (
	input logic GPU_CLK,
	input logic reset,
	input gpu_bus_pkg::z80_ctl_t ctl_in,	// raw pins, asynchronous to GPU_CLK
	output gpu_bus_pkg::z80_ctl_t ctl_out	// same strobes, Z80_SYNC_STAGES cycles later
);
	import gpu_bus_pkg::*;

	// strobes idle high, clock idle low, so nothing looks like an edge after reset
	localparam z80_ctl_t CTL_IDLE = '{mreq_n: 1'b1, m1_n: 1'b1, wr_n: 1'b1, rd_n: 1'b1,
		clk: 1'b0};

	z80_ctl_t sync_q [`Z80_SYNC_STAGES];	// stage 0 samples the pins

	always_ff @(posedge GPU_CLK) begin
		if (reset) begin
			for (int i = 0; i < `Z80_SYNC_STAGES; i++) sync_q[i] <= CTL_IDLE;	// park inactive
		end else begin
			sync_q[0] <= ctl_in;	// first flop may go metastable
			for (int i = 1; i < `Z80_SYNC_STAGES; i++) sync_q[i] <= sync_q[i-1];	// settle
		end
	end

	assign ctl_out = sync_q[`Z80_SYNC_STAGES-1];	// last stage is safe to decode

endmodule

/* design/z80_bridge.sv */
`timescale 1ns/1ps
`include "gpu_bus_consts.svh"

module z80_bridge #(
	parameter logic [2:0] mem_range = `Z80_MEM_RANGE,	// addr[21:19] that hits gpu ram
	parameter int wr_delay = `Z80_WR_DELAY	// 245 settle time before data latch
) (
	input logic GPU_CLK,
	input logic reset,
	input gpu_bus_pkg::z80_ctl_t ctl,	// already synchronized
	input logic [21:0] z80_addr,	// stable for the whole strobe
	input logic [7:0] z80_wdata,	// stable for the whole write strobe
	input gpu_bus_pkg::gpu_rsp_t rsp,	// from mux port a
	output gpu_bus_pkg::gpu_req_t req,	// to mux port a
	output gpu_bus_pkg::z80_drv_t drv	// 245 control and read data
);

	// ******************************
	// cycle decode
	// ******************************

	logic last_wr_n;	// previous wr_n, for the falling edge
	logic last_rd_n;	// previous rd_n, for the rising edge
	logic last_clk;	// previous z80 clock, for the rising edge
	logic rd_active;	// read accepted, bus not yet released
	logic [wr_delay+1:0] wr_seq;	// one hot walks through the write steps

	logic in_window;
	logic mem_cycle;
	logic wr_start;
	logic rd_start;
	logic rd_end;

	assign in_window = (z80_addr[21:19] == mem_range);	// 512KB gpu window
	assign mem_cycle = ~ctl.mreq_n && ctl.m1_n;	// memory access, opcode fetches excluded
	assign wr_start = in_window && mem_cycle && ~ctl.wr_n && last_wr_n;	// wr_n just fell
	// reads start on a z80 clock rise so the address is settled
	assign rd_start = in_window && mem_cycle && ~ctl.rd_n && ctl.clk && ~last_clk
		&& ~rd_active;
	assign rd_end = rd_active && ctl.rd_n && ~last_rd_n;	// z80 finished sampling data

	// ******************************
	// write sequencer and read control
	// ******************************

	always_ff @(posedge GPU_CLK) begin
		if (reset) begin
			last_wr_n <= 1'b1;
			last_rd_n <= 1'b1;
			last_clk <= 1'b0;
			rd_active <= 1'b0;
			wr_seq <= '0;
			req.wr_ena <= 1'b0;
			req.rd_req <= 1'b0;
			drv.data_dir <= 1'b1;	// pins listen after reset
			drv.xlat_oe <= 1'b0;
			drv.rdata_ena <= 1'b0;
		end else begin
			last_wr_n <= ctl.wr_n;
			last_rd_n <= ctl.rd_n;
			last_clk <= ctl.clk;
			wr_seq <= {wr_seq[wr_delay:0], wr_start};	// step one per cycle

			// write path, t = wr_start cycle
			if (wr_start) begin
				drv.data_dir <= 1'b1;	// 245 toward fpga at t+1
				drv.rdata_ena <= 1'b0;	// fpga pins stay inputs
			end
			if (wr_seq[0]) drv.xlat_oe <= 1'b1;	// 245 on at t+2
			req.wr_ena <= wr_seq[wr_delay];	// single strobe at t+wr_delay+2
			if (wr_seq[wr_delay]) begin
				req.addr <= z80_addr[`GPU_ADDR_BITS-1:0];	// crop to window offset
				req.wdata <= z80_wdata;	// data has settled through the 245
			end
			if (wr_seq[wr_delay+1]) drv.xlat_oe <= 1'b0;	// 245 off right after the strobe

			// read path
			req.rd_req <= rd_start;	// one-shot toward the mux
			if (rd_start) begin
				rd_active <= 1'b1;
				req.addr <= z80_addr[`GPU_ADDR_BITS-1:0];
				drv.data_dir <= 1'b0;	// 245 toward z80
				drv.xlat_oe <= 1'b1;
			end
			if (rsp.rd_rdy && rd_active) begin
				drv.rdata <= rsp.rdata;	// hold until rd_n rises
				drv.rdata_ena <= 1'b1;	// drive the data pins
			end
			if (rd_end) begin	// wins over a late rd_rdy
				rd_active <= 1'b0;
				drv.xlat_oe <= 1'b0;
				drv.rdata_ena <= 1'b0;
				drv.data_dir <= 1'b1;	// back to listening
			end
		end
	end

	// ******************************
	// checks
	// ******************************

	// a write sequence and a read never overlap on the z80 bus
	assert property (@(posedge GPU_CLK) disable iff (reset) !(req.wr_ena && req.rd_req))
		else $error("bridge issued write and read in one cycle");

	// the mux takes every write strobe as a new byte
	assert property (@(posedge GPU_CLK) disable iff (reset) req.wr_ena |=> !req.wr_ena)
		else $error("bridge write strobe held two cycles");

endmodule

/* design/gpu_ram_mux.sv */
`timescale 1ns/1ps
`include "gpu_bus_consts.svh"

module gpu_ram_mux (
	input logic GPU_CLK,
	input logic reset,
	input gpu_bus_pkg::gpu_req_t a_req,	// bridge, higher priority
	input gpu_bus_pkg::gpu_req_t b_req,	// display fetch
	output gpu_bus_pkg::gpu_rsp_t a_rsp,
	output gpu_bus_pkg::gpu_rsp_t b_rsp,
	output logic [`GPU_ADDR_BITS-1:0] ram_addr,
	output logic ram_we,
	output logic [7:0] ram_wdata,
	input logic [7:0] ram_rdata	// one cycle after ram_addr
);
	import gpu_bus_pkg::*;

	gpu_req_t a_slot;	// pending access of port a, flags say what is pending
	gpu_req_t b_slot;	// same for port b
	logic a_pend;
	logic b_pend;
	logic grant_a;
	logic grant_b;
	logic [1:0] rdy_tag;	// bit 0 port a, bit 1 port b, lines up with ram latency

	assign a_pend = a_slot.wr_ena || a_slot.rd_req;
	assign b_pend = b_slot.wr_ena || b_slot.rd_req;
	assign grant_a = a_pend;	// a always wins
	assign grant_b = b_pend && !grant_a;	// b waits out every a access

	// ******************************
	// ram port, one access per cycle
	// ******************************

	assign ram_addr = grant_a ? a_slot.addr : b_slot.addr;
	assign ram_wdata = grant_a ? a_slot.wdata : b_slot.wdata;
	assign ram_we = grant_a ? a_slot.wr_ena : (grant_b && b_slot.wr_ena);

	always_ff @(posedge GPU_CLK) begin
		if (reset) begin
			a_slot.wr_ena <= 1'b0;
			a_slot.rd_req <= 1'b0;
			b_slot.wr_ena <= 1'b0;
			b_slot.rd_req <= 1'b0;
			rdy_tag <= 2'b00;
		end else begin
			// served slots empty out
			if (grant_a) begin
				a_slot.wr_ena <= 1'b0;
				a_slot.rd_req <= 1'b0;
			end
			if (grant_b) begin
				b_slot.wr_ena <= 1'b0;
				b_slot.rd_req <= 1'b0;
			end
			// new strobes are always taken, one outstanding per port
			if (a_req.wr_ena || a_req.rd_req) a_slot <= a_req;
			if (b_req.wr_ena || b_req.rd_req) b_slot <= b_req;
			// remember who reads, ready when the byte comes out of ram
			rdy_tag <= {grant_b && b_slot.rd_req, grant_a && a_slot.rd_req};
		end
	end

	// ******************************
	// responses
	// ******************************

	assign a_rsp.rdata = ram_rdata;	// both see the ram output
	assign a_rsp.rd_rdy = rdy_tag[0];
	assign b_rsp.rdata = ram_rdata;
	assign b_rsp.rd_rdy = rdy_tag[1];

	// the ram returns one byte per cycle, so only one port can be answered
	assert property (@(posedge GPU_CLK) disable iff (reset) !(a_rsp.rd_rdy && b_rsp.rd_rdy))
		else $error("rd_rdy on both mux ports at once");

endmodule

/* design/gpu_ram.sv */
`timescale 1ns/1ps
`include "gpu_bus_consts.svh"

module gpu_ram #(
	parameter int addr_bits = `GPU_ADDR_BITS	// byte address width
) (
	input logic GPU_CLK,
	input logic [addr_bits-1:0] addr,
	input logic we,	// write this cycle
	input logic [7:0] wdata,
	output logic [7:0] rdata	// byte at addr, one cycle later
);

	// ******************************
	// byte storage
	// ******************************

	logic [7:0] mem [2**addr_bits];	// maps to block ram

	always_ff @(posedge GPU_CLK) begin
		if (we) mem[addr] <= wdata;	// write first into the array
		rdata <= mem[addr];	// read gets the old byte on a write cycle
	end

endmodule

/* design/z80_gpu_top.sv */
`timescale 1ns/1ps
`include "gpu_bus_consts.svh"

module z80_gpu_top (
	input logic GPU_CLK,
	input logic reset,
	input gpu_bus_pkg::z80_ctl_t z80_ctl,	// raw z80 control pins
	input logic [21:0] z80_addr,
	input logic [7:0] z80_wdata,
	output gpu_bus_pkg::z80_drv_t z80_drv,	// 245 control and read data, tristate in wrapper
	input gpu_bus_pkg::gpu_req_t disp_req,	// display fetch port
	output gpu_bus_pkg::gpu_rsp_t disp_rsp
);
	import gpu_bus_pkg::*;

	z80_ctl_t ctl_sync;	// z80 strobes in GPU_CLK domain
	gpu_req_t br_req;	// bridge to mux port a
	gpu_rsp_t br_rsp;
	logic [`GPU_ADDR_BITS-1:0] ram_addr;
	logic ram_we;
	logic [7:0] ram_wdata;
	logic [7:0] ram_rdata;

	// ******************************
	// z80 side
	// ******************************

	z80_bus_sync sync_i (
		.GPU_CLK (GPU_CLK),
		.reset (reset),
		.ctl_in (z80_ctl),
		.ctl_out (ctl_sync)
	);

	z80_bridge bridge_i (
		.GPU_CLK (GPU_CLK),
		.reset (reset),
		.ctl (ctl_sync),
		.z80_addr (z80_addr),	// no sync, held for the whole strobe
		.z80_wdata (z80_wdata),
		.rsp (br_rsp),
		.req (br_req),
		.drv (z80_drv)
	);

	// ******************************
	// ram side
	// ******************************

	gpu_ram_mux mux_i (
		.GPU_CLK (GPU_CLK),
		.reset (reset),
		.a_req (br_req),	// bridge has priority
		.b_req (disp_req),
		.a_rsp (br_rsp),
		.b_rsp (disp_rsp),
		.ram_addr (ram_addr),
		.ram_we (ram_we),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

	gpu_ram ram_i (
		.GPU_CLK (GPU_CLK),
		.addr (ram_addr),
		.we (ram_we),
		.wdata (ram_wdata),
		.rdata (ram_rdata)
	);

endmodule

/* test/tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen (
	output logic GPU_CLK,
	output logic reset
);

	initial begin
		GPU_CLK = 1'b0;
		forever #50 GPU_CLK = ~GPU_CLK;	// 100 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge GPU_CLK);	// two rising edges in reset
		@(negedge GPU_CLK);
		reset = 1'b0;	// dropped on a falling edge, same as the other inputs
	end

endmodule

/* test/tb_z80_gpu.sv */
`timescale 1ns/1ps
`include "gpu_bus_consts.svh"

module tb_z80_gpu;
	import gpu_bus_pkg::*;

	// one line of the stim file
	typedef struct packed {
		logic [7:0] kind;	// W R F D X
		logic [23:0] addr;	// z80 address or ram address for D
		logic [7:0] data;	// write byte or expected byte
		logic [23:0] addr2;	// display address of an X line
		logic [7:0] data2;	// expected display byte of an X line
		logic use_ref;	// random write or expected byte from earlier writes
	} stim_t;

	logic GPU_CLK;
	logic reset;
	z80_ctl_t z80_ctl;
	logic [21:0] z80_addr;
	logic [7:0] z80_wdata;
	z80_drv_t z80_drv;
	gpu_req_t disp_req;
	gpu_rsp_t disp_rsp;

	stim_t stim_q [$];
	logic [7:0] ref_mem [int];	// bytes written by the z80 keyed by ram address
	int seed = 90786;
	bit stim_loaded;
	int bad_stim_lines;	// stim lines that did not parse
	int cyc;	// GPU_CLK count bumped on every falling edge
	int phase;	// GPU_CLK cycles since the last z80 clock toggle
	int test_errs;
	int tests_run;
	int tests_failed;
	int checks_failed;
	bit saw_oe;
	bit saw_dir_low;
	bit saw_rena;
	bit rena_in_rd;	// read data driven while RDn still low
	int rena_cyc;
	int last_rena_cyc;
	int rdy_count;
	int rdy_cyc;
	logic [7:0] rena_data;
	logic [7:0] rdy_data;

	tb_clock_gen clk_i (.GPU_CLK (GPU_CLK), .reset (reset));

	z80_gpu_top dut_i (
		.GPU_CLK (GPU_CLK),
		.reset (reset),
		.z80_ctl (z80_ctl),
		.z80_addr (z80_addr),
		.z80_wdata (z80_wdata),
		.z80_drv (z80_drv),
		.disp_req (disp_req),
		.disp_rsp (disp_rsp)
	);

	// ******************************
	// bus model helpers
	// ******************************

	// one GPU_CLK cycle that samples the outputs and then steps the modeled z80 clock
	task automatic tick();
		@(negedge GPU_CLK);
		cyc++;
		if (z80_drv.xlat_oe) saw_oe = 1'b1;
		if (!z80_drv.data_dir) saw_dir_low = 1'b1;
		if (z80_drv.rdata_ena) begin
			if (!saw_rena) begin
				rena_cyc = cyc;	// first cycle with data on the pins
				rena_data = z80_drv.rdata;
			end
			saw_rena = 1'b1;
			last_rena_cyc = cyc;
			if (!z80_ctl.rd_n) rena_in_rd = 1'b1;
		end
		if (disp_rsp.rd_rdy) begin
			rdy_count++;
			if (rdy_count == 1) begin
				rdy_cyc = cyc;
				rdy_data = disp_rsp.rdata;	// valid only in the rd_rdy cycle
			end
		end
		phase++;
		if (phase == 8) begin
			phase = 0;
			z80_ctl.clk = ~z80_ctl.clk;	// z80 clock is 16 GPU_CLK cycles
		end
	endtask

	task automatic clear_monitor();
		saw_oe = 1'b0;
		saw_dir_low = 1'b0;
		saw_rena = 1'b0;
		rena_in_rd = 1'b0;
		rdy_count = 0;
	endtask

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		assert (got === exp) else begin
			$display("Fail %s got %h expected %h", name, got, exp);
			test_errs++;
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond) else begin
			$display("%s", what);
			test_errs++;
		end
	endtask

	task automatic expect_from_ref(input logic [23:0] addr, inout logic [7:0] exp);
		if (ref_mem.exists(int'(addr[`GPU_ADDR_BITS-1:0]))) begin
			exp = ref_mem[int'(addr[`GPU_ADDR_BITS-1:0])];
		end else begin
			$display("no earlier write to address %h gives the expected byte", addr);
			test_errs++;
		end
	endtask

	// z80 memory cycle with strobes held 4 z80 clocks and a display read for X
	task automatic z80_access(input stim_t s, input logic [7:0] exp_z80, input logic [7:0] exp_disp);
		bit hit;
		int c0;
		int cr;
		int d0;
		hit = (s.addr[21:19] == `Z80_MEM_RANGE) && (s.kind != "F");
		do begin
			tick();
		end while (!(z80_ctl.clk && phase == 0));	// strobes fall with a z80 clock rise
		clear_monitor();
		c0 = cyc;
		d0 = 0;
		z80_addr = s.addr[21:0];
		z80_wdata = exp_z80;
		z80_ctl.mreq_n = 1'b0;
		z80_ctl.m1_n = (s.kind != "F");	// low only for opcode fetch
		z80_ctl.wr_n = (s.kind != "W");
		z80_ctl.rd_n = (s.kind == "W");
		for (int i = 0; i < 64; i++) begin
			tick();
			if (s.kind == "X" && i == 2) begin	// meets the bridge request at the mux
				disp_req.addr = s.addr2[`GPU_ADDR_BITS-1:0];
				disp_req.rd_req = 1'b1;
				d0 = cyc;
			end else begin
				disp_req.rd_req = 1'b0;
			end
		end
		z80_ctl.mreq_n = 1'b1;
		z80_ctl.m1_n = 1'b1;
		z80_ctl.wr_n = 1'b1;
		z80_ctl.rd_n = 1'b1;
		cr = cyc;	// strobes released here
		repeat (8) tick();
		if (!hit) begin
			check_true(!saw_oe, "245 enabled for a cycle that is not a gpu access");
			check_true(!saw_rena, "data pins driven for a cycle that is not a gpu access");
		end else if (s.kind == "W") begin
			check_true(saw_oe, "245 never enabled during the write");
			check_true(!saw_dir_low, "245 turned toward the z80 during a write");
		end else begin
			check_true(saw_dir_low, "245 never turned toward the z80 during the read");
			check_true(rena_in_rd, "read data not driven before RDn rose");
			if (saw_rena) begin
				check_true(rena_cyc - c0 <= 8, "read data came over 8 cycles after RDn fell");
				check_value("z80_drv.rdata", rena_data, exp_z80);
				check_true(last_rena_cyc < cr + 4, "rdata_ena still high 4 cycles after RDn rose");
			end
		end
		if (s.kind == "X") begin
			check_true(rdy_count == 1, "display port did not see exactly one rd_rdy pulse");
			if (rdy_count > 0) begin
				check_true(rdy_cyc - d0 <= 8, "display rd_rdy came over 8 cycles late");
				check_value("disp_rsp.rdata", rdy_data, exp_disp);
			end
		end
	endtask

	task automatic disp_read(input logic [`GPU_ADDR_BITS-1:0] addr, input logic [7:0] exp);
		int d0;
		tick();
		clear_monitor();
		disp_req.addr = addr;
		disp_req.rd_req = 1'b1;	// one cycle strobe
		d0 = cyc;
		tick();
		disp_req.rd_req = 1'b0;
		repeat (8) tick();
		check_true(rdy_count == 1, "display port did not see exactly one rd_rdy pulse");
		if (rdy_count > 0) begin
			check_true(rdy_cyc - d0 == 2, "display rd_rdy not 2 cycles after an idle request");
			check_value("disp_rsp.rdata", rdy_data, exp);
		end
	endtask

	task automatic finish_test(input int num, input string what);
		tests_run++;
		if (test_errs == 0) begin
			$display("test %0d %s ok", num, what);
		end else begin
			$display("test %0d %s failed with %0d errors", num, what, test_errs);
			tests_failed++;
		end
		checks_failed += test_errs;
		test_errs = 0;
	endtask

	// ******************************
	// main sequence
	// ******************************

	initial begin
		int fd;
		int n;
		string line;
		stim_t s;
		logic [7:0] k;
		logic [23:0] a;
		logic [7:0] d;
		logic [23:0] a2;
		logic [7:0] d2;
		logic u;
		logic [7:0] exp_z80;
		logic [7:0] exp_disp;
		z80_ctl = '{mreq_n: 1'b1, m1_n: 1'b1, wr_n: 1'b1, rd_n: 1'b1, clk: 1'b0};	// bus idle
		z80_addr = '0;
		z80_wdata = '0;
		disp_req = '0;
		cyc = 0;
		phase = 0;
		test_errs = 0;
		tests_run = 0;
		tests_failed = 0;
		checks_failed = 0;
		bad_stim_lines = 0;
		fd = $fopen("test/z80_gpu_stim.txt", "r");
		if (fd == 0) $display("stim file test/z80_gpu_stim.txt could not be opened");
		while (fd != 0 && !$feof(fd)) begin
			n = $fgets(line, fd);
			if (n > 1 && line[0] != "#") begin	// skip blank and comment lines
				n = $sscanf(line, "%c %h %h %h %h %h", k, a, d, a2, d2, u);
				if (n == 6) begin
					s.kind = k;
					s.addr = a;
					s.data = d;
					s.addr2 = a2;
					s.data2 = d2;
					s.use_ref = u;
					stim_q.push_back(s);
				end else begin
					$display("stim line could not be parsed: %s", line);
					bad_stim_lines++;
				end
			end
		end
		if (fd != 0) $fclose(fd);
		stim_loaded = (stim_q.size() > 0);
		wait (reset == 1'b0);
		clear_monitor();
		repeat (6) begin	// outputs must sit idle with no traffic
			tick();
			check_value("z80_drv.xlat_oe", 8'(z80_drv.xlat_oe), 8'h00);
			check_value("z80_drv.rdata_ena", 8'(z80_drv.rdata_ena), 8'h00);
			check_value("z80_drv.data_dir", 8'(z80_drv.data_dir), 8'h01);
			check_value("disp_rsp.rd_rdy", 8'(disp_rsp.rd_rdy), 8'h00);
		end
		finish_test(0, "reset state");
		foreach (stim_q[i]) begin
			s = stim_q[i];
			exp_z80 = s.data;
			exp_disp = s.data2;
			if (s.use_ref && s.kind == "W") exp_z80 = 8'($random(seed));
			else if (s.use_ref && s.kind != "F") expect_from_ref(s.addr, exp_z80);
			if (s.use_ref && s.kind == "X") expect_from_ref(s.addr2, exp_disp);
			case (s.kind)
				"W", "R", "F", "X": z80_access(s, exp_z80, exp_disp);
				"D": disp_read(s.addr[`GPU_ADDR_BITS-1:0], exp_z80);
				default: begin
					$display("unknown operation kind %c in stim line %0d", s.kind, i + 1);
					test_errs++;
				end
			endcase
			if (s.kind == "W" && s.addr[21:19] == `Z80_MEM_RANGE) begin
				ref_mem[int'(s.addr[`GPU_ADDR_BITS-1:0])] = exp_z80;	// ram now holds it
			end
			finish_test(i + 1, $sformatf("%c %h", s.kind, s.addr));
		end
		$display("tests run %0d, failed %0d, failed checks %0d", tests_run, tests_failed,
			checks_failed);
		if (stim_loaded && bad_stim_lines == 0 && tests_failed == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	// 80 z80 clocks of 16 GPU_CLK cycles per stim line plus one spare line for reset
	initial begin
		wait (stim_loaded);
		#((stim_q.size() + 1) * 80 * 16 * 100);
		$display("watchdog expired before the bus operations finished");
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

/* test/z80_gpu_stim.txt */
# kind z80_addr data disp_addr disp_data use_ref
# kind: W z80 write, R z80 read, F opcode fetch, D display read, X z80 and display read together
# data is the write byte or the expected byte, D reads the ram address in the z80_addr column
# use_ref 1: W writes a random byte, reads expect the bytes written earlier
W 180010 5a 000000 00 0
R 180010 5a 000000 00 0
W 1a5a5a c3 000000 00 0
R 1a5a5a c3 000000 00 0
W 080010 33 000000 00 0
R 180010 5a 000000 00 0
R 080010 00 000000 00 0
F 180010 00 000000 00 0
W 1fffff 00 000000 00 1
R 1fffff 00 000000 00 1
D 1fffff 00 000000 00 1
D 1a5a5a c3 000000 00 0
W 180100 00 000000 00 1
W 180101 00 000000 00 1
D 180100 00 000000 00 1
X 180101 00 180100 00 1
X 1a5a5a c3 180010 5a 0
W 1c0000 e7 000000 00 0
F 1c0000 00 000000 00 0
R 1c0000 e7 000000 00 0
W 180010 a5 000000 00 0
X 180010 a5 1c0000 e7 0
W 380010 77 000000 00 0
R 180010 a5 000000 00 0

/* sim.f */
+incdir+include
design/gpu_bus_pkg.sv
design/z80_bus_sync.sv
design/z80_bridge.sv
design/gpu_ram_mux.sv
design/gpu_ram.sv
design/z80_gpu_top.sv
test/tb_clock_gen.sv
test/tb_z80_gpu.sv

/* run_sim.sh */
#!/bin/sh
# build and run the Z80 to GPU RAM bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 -f sim.f --top-module tb_z80_gpu \
	-o tb_z80_gpu > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_z80_gpu > sim.log 2>&1 ; cat sim.log

grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "simulation ended without a result"; exit 1; }
exit 0
